// ==== hdl/bus_consts.svh ====
//////////////////////////////////////////////////////////////////////
// Fixed constants of the CPU bus and the peripheral bus
// Included by the packages and by RTL that needs lane or burst sizes
//////////////////////////////////////////////////////////////////////

`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// Width of one byte lane, four lanes make a long word
`define LANE_BITS 8

// Long words moved by one line transfer
`define BURST_BEATS 4

// Peripheral address of the second half of a split cycle
`define SECOND_HALF_ADDR 2

// Encoding width of the sequencer state
`define STATE_BITS 3

`endif

// ==== hdl/busTypesPkg.sv ====
//////////////////////////////////////////////////////////////////////
// Types that describe the signals on the bus itself
// Termination pair decode and the two views of a data word
//////////////////////////////////////////////////////////////////////

`include "bus_consts.svh"

package busTypesPkg;

    // Termination pair as {tackN, teaN}, both active low
    typedef enum logic [1:0] {
        TERM_RETRY  = 2'b00,
        TERM_NORMAL = 2'b01,
        TERM_ERROR  = 2'b10,
        TERM_WAIT   = 2'b11
    } termCode;

    // Two 16-bit halves of a long word
    // High half sits on the upper two lanes, address 0 of a word port
    typedef struct packed {
        logic [2*`LANE_BITS-1:0] high;
        logic [2*`LANE_BITS-1:0] low;
    } wordPair;

    // One long word on four lanes, seen whole or as two words
    typedef union packed {
        logic [4*`LANE_BITS-1:0] longWord;
        wordPair                 words;
    } dataWord;

endpackage

// ==== hdl/cycleTypesPkg.sv ====
//////////////////////////////////////////////////////////////////////
// Types that describe one CPU transfer and its progress
// Size code as driven on siz and the sequencer state encoding
//////////////////////////////////////////////////////////////////////

`include "bus_consts.svh"

package cycleTypesPkg;

    // 68040 transfer size on the two siz lines
    typedef enum logic [1:0] {
        SIZE_LONG = 2'b00,
        SIZE_BYTE = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_LINE = 2'b11
    } sizeCode;

    // Sequencer states for local cycles and burst beats
    typedef enum logic [`STATE_BITS-1:0] {
        SEQ_IDLE         = 3'd0,
        SEQ_START        = 3'd1,
        SEQ_WAIT_FIRST   = 3'd2,
        SEQ_START_SECOND = 3'd3,
        SEQ_WAIT_SECOND  = 3'd4,
        SEQ_NEXT_BEAT    = 3'd5
    } seqState;

endpackage

// ==== hdl/cycleDecoder.sv ====
//////////////////////////////////////////////////////////////////////
// First stage of the bus sizer
// Captures a CPU transfer start while idle and decodes size and port
//////////////////////////////////////////////////////////////////////

module cycleDecoder (
    input  logic                   CLK40,
    input  logic                   RESETn,
    input  logic                   tsCpuN,
    input  logic                   rnw,
    input  cycleTypesPkg::sizeCode siz,
    input  logic [1:0]             addrCpu,
    input  logic                   portSize,
    input  logic                   busy,
    output logic                   startPulse,
    output logic                   isRead,
    output logic                   isLine,
    output logic                   split,
    output logic                   flipLow
);

    import cycleTypesPkg::*;

    logic accept;
    logic longLike;
    logic splitNext;

    // New start only when no cycle is in flight
    assign accept = !tsCpuN && !busy;

    // Long and line both move whole long words
    assign longLike = (siz == SIZE_LONG) || (siz == SIZE_LINE);

    // portSize high marks a 16-bit port
    assign splitNext = portSize && longLike;

    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            startPulse <= 1'b0;
            isRead     <= 1'b0;
            isLine     <= 1'b0;
            split      <= 1'b0;
            flipLow    <= 1'b0;
        end else begin
            // Single cycle strobe toward the sequencer
            startPulse <= accept;
            if (accept) begin
                isRead  <= rnw;
                isLine  <= (siz == SIZE_LINE);
                split   <= splitNext;
                // Word or byte at address 2 of a word port, data on the high lanes
                flipLow <= portSize && addrCpu[1] && !splitNext;
            end
        end
    end

endmodule

// ==== hdl/cycleSequencer.sv ====
//////////////////////////////////////////////////////////////////////
// Second stage of the bus sizer
// Runs the local peripheral cycles, splits long words for word ports,
// repeats line beats and gates the acknowledge back to the CPU
//////////////////////////////////////////////////////////////////////

`include "bus_consts.svh"

module cycleSequencer (
    input  logic CLK40,
    input  logic RESETn,
    input  logic startPulse,
    input  logic isRead,
    input  logic isLine,
    input  logic split,
    input  logic flipLow,
    input  logic tackN,
    input  logic teaN,
    input  logic tbiN,
    output logic tsAmigaN,
    output logic secondHalf,
    output logic taDisable,
    output logic latchHigh,
    output logic useLatch,
    output logic flipActive,
    output logic readActive,
    output logic writeActive,
    output logic busy
);

    import busTypesPkg::*;
    import cycleTypesPkg::*;

    seqState state;
    seqState nextState;
    termCode term;

    logic [$clog2(`BURST_BEATS)-1:0] beatCount;
    logic lastBeat;
    logic moreBeats;
    logic inFirst;
    logic inSecond;

    assign term = termCode'({tackN, teaN});

    // Beat count holds the beats already finished in this line
    assign lastBeat  = (32'(beatCount) == `BURST_BEATS - 1);
    assign moreBeats = isLine && tbiN && !lastBeat;

    //////////////////////////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            SEQ_IDLE: begin
                if (startPulse) begin
                    nextState = SEQ_START;
                end
            end
            SEQ_START: begin
                nextState = SEQ_WAIT_FIRST;
            end
            SEQ_WAIT_FIRST, SEQ_WAIT_SECOND: begin
                case (term)
                    TERM_NORMAL: begin
                        // First half of a split goes on to address 2
                        if (state == SEQ_WAIT_FIRST && split) begin
                            nextState = SEQ_START_SECOND;
                        end else if (moreBeats) begin
                            nextState = SEQ_NEXT_BEAT;
                        end else begin
                            nextState = SEQ_IDLE;
                        end
                    end
                    TERM_RETRY, TERM_ERROR: begin
                        nextState = SEQ_IDLE;
                    end
                    TERM_WAIT: begin
                        nextState = state;
                    end
                    default: begin
                        nextState = SEQ_IDLE;
                    end
                endcase
            end
            SEQ_START_SECOND: begin
                nextState = SEQ_WAIT_SECOND;
            end
            SEQ_NEXT_BEAT: begin
                nextState = SEQ_START;
            end
            default: begin
                nextState = SEQ_IDLE;
            end
        endcase
    end

    // Which half the sequencer will be in after this edge
    assign inFirst  = (nextState == SEQ_START) || (nextState == SEQ_WAIT_FIRST);
    assign inSecond = (nextState == SEQ_START_SECOND) || (nextState == SEQ_WAIT_SECOND);

    //////////////////////////////////////////////////////////////////////
    // State and registered controls
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            state       <= SEQ_IDLE;
            beatCount   <= '0;
            tsAmigaN    <= 1'b1;
            secondHalf  <= 1'b0;
            taDisable   <= 1'b0;
            useLatch    <= 1'b0;
            flipActive  <= 1'b0;
            readActive  <= 1'b0;
            writeActive <= 1'b0;
        end else begin
            state <= nextState;

            if (state == SEQ_IDLE) begin
                beatCount <= '0;
            end else if (nextState == SEQ_NEXT_BEAT) begin
                beatCount <= beatCount + 1'b1;
            end

            // One low cycle per local start, the second half after a turnaround cycle
            tsAmigaN <= !((nextState == SEQ_START) || (state == SEQ_START_SECOND));

            secondHalf <= inSecond;
            useLatch   <= inSecond && isRead;
            flipActive <= inSecond || (inFirst && flipLow);

            // Mask the first half acknowledge, held one cycle past its edge
            taDisable <= split && (inFirst || nextState == SEQ_START_SECOND);

            readActive  <= (nextState != SEQ_IDLE) && isRead;
            writeActive <= (nextState != SEQ_IDLE) && !isRead;
        end
    end

    // Sampled by the lane router on the same edge as the first half ends
    assign latchHigh = (state == SEQ_WAIT_FIRST) && (term == TERM_NORMAL) && split && isRead;

    // Start strobe counts as busy so the decoder cannot take a second one
    assign busy = (state != SEQ_IDLE) || startPulse;

endmodule

// ==== hdl/laneRouter.sv ====
//////////////////////////////////////////////////////////////////////
// Third stage of the bus sizer
// Steers words between the byte lanes of both buses, holds the high
// word of a split read and drives the data output enables
//////////////////////////////////////////////////////////////////////

`include "bus_consts.svh"

module laneRouter (
    input  logic                    CLK40,
    input  logic                    RESETn,
    input  logic [4*`LANE_BITS-1:0] dataCpuIn,
    input  logic [4*`LANE_BITS-1:0] dataAmigaIn,
    input  logic                    latchHigh,
    input  logic                    useLatch,
    input  logic                    flipActive,
    input  logic                    readActive,
    input  logic                    writeActive,
    output logic [4*`LANE_BITS-1:0] dataCpuOut,
    output logic                    dataCpuOe,
    output logic [4*`LANE_BITS-1:0] dataAmigaOut,
    output logic                    dataAmigaOe
);

    import busTypesPkg::*;

    dataWord cpuWord;
    dataWord amigaWord;
    dataWord cpuRead;
    dataWord amigaWrite;

    logic [2*`LANE_BITS-1:0] highLatch;

    assign cpuWord.longWord   = dataCpuIn;
    assign amigaWord.longWord = dataAmigaIn;

    // First word of a split read, taken at its termination edge
    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            highLatch <= '0;
        end else if (latchHigh) begin
            highLatch <= amigaWord.words.high;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Lane steering
    //////////////////////////////////////////////////////////////////////

    // Read path, a word port always answers on the high lanes
    always_comb begin
        cpuRead.words.high = useLatch ? highLatch : amigaWord.words.high;
        cpuRead.words.low  = flipActive ? amigaWord.words.high : amigaWord.words.low;
    end

    // Write path, CPU low word moves up for address 2 of a word port
    always_comb begin
        amigaWrite.words.high = flipActive ? cpuWord.words.low : cpuWord.words.high;
        amigaWrite.words.low  = cpuWord.words.low;
    end

    assign dataCpuOut   = cpuRead.longWord;
    assign dataAmigaOut = amigaWrite.longWord;

    // Direction follows the active cycle only
    assign dataCpuOe   = readActive;
    assign dataAmigaOe = writeActive;

endmodule

// ==== hdl/busSizer.sv ====
//////////////////////////////////////////////////////////////////////
// Bus sizing bridge between the CPU bus and the peripheral bus
// Decoder, sequencer and lane router in a chain, plus the termination
// and address pass-through toward both buses
//////////////////////////////////////////////////////////////////////

`include "bus_consts.svh"

module busSizer (
    input  logic                    CLK40,
    input  logic                    RESETn,
    input  logic                    tsCpuN,
    input  logic                    rnw,
    input  cycleTypesPkg::sizeCode  siz,
    input  logic [1:0]              addrCpu,
    input  logic                    portSize,
    input  logic                    tackN,
    input  logic                    teaN,
    input  logic                    tbiN,
    input  logic                    tciN,
    input  logic [4*`LANE_BITS-1:0] dataCpuIn,
    input  logic [4*`LANE_BITS-1:0] dataAmigaIn,
    output logic                    tsAmigaN,
    output logic [1:0]              addrAmiga,
    output logic                    taCpuN,
    output logic                    teaCpuN,
    output logic                    tbiCpuN,
    output logic                    tciCpuN,
    output logic [4*`LANE_BITS-1:0] dataCpuOut,
    output logic                    dataCpuOe,
    output logic [4*`LANE_BITS-1:0] dataAmigaOut,
    output logic                    dataAmigaOe
);

    logic startPulse, isRead, isLine, split, flipLow, busy;
    logic secondHalf, taDisable, latchHigh, useLatch, flipActive;
    logic readActive, writeActive;

    cycleDecoder decoder0 (
        .CLK40(CLK40), .RESETn(RESETn), .tsCpuN(tsCpuN), .rnw(rnw), .siz(siz),
        .addrCpu(addrCpu), .portSize(portSize), .busy(busy), .startPulse(startPulse),
        .isRead(isRead), .isLine(isLine), .split(split), .flipLow(flipLow)
    );

    cycleSequencer sequencer0 (
        .CLK40(CLK40), .RESETn(RESETn), .startPulse(startPulse), .isRead(isRead),
        .isLine(isLine), .split(split), .flipLow(flipLow), .tackN(tackN), .teaN(teaN),
        .tbiN(tbiN), .tsAmigaN(tsAmigaN), .secondHalf(secondHalf), .taDisable(taDisable),
        .latchHigh(latchHigh), .useLatch(useLatch), .flipActive(flipActive),
        .readActive(readActive), .writeActive(writeActive), .busy(busy)
    );

    laneRouter router0 (
        .CLK40(CLK40), .RESETn(RESETn), .dataCpuIn(dataCpuIn), .dataAmigaIn(dataAmigaIn),
        .latchHigh(latchHigh), .useLatch(useLatch), .flipActive(flipActive),
        .readActive(readActive), .writeActive(writeActive), .dataCpuOut(dataCpuOut),
        .dataCpuOe(dataCpuOe), .dataAmigaOut(dataAmigaOut), .dataAmigaOe(dataAmigaOe)
    );

    // Address 2 for the low word of a split, CPU address otherwise
    assign addrAmiga = secondHalf ? 2'(`SECOND_HALF_ADDR) : addrCpu;

    // Acknowledge hidden from the CPU during the first half
    assign taCpuN  = taDisable ? 1'b1 : tackN;
    assign teaCpuN = teaN;
    assign tbiCpuN = tbiN;
    assign tciCpuN = tciN;

endmodule

// ==== bench/clockGen.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset source
// 40 ns CLK40, RESETn held low for the first 16 rising edges
//////////////////////////////////////////////////////////////////////

module clockGen (
    output logic CLK40,
    output logic RESETn
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        CLK40 = 1'b0;
        forever #20 CLK40 = ~CLK40;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        RESETn = 1'b0;
        repeat (16) @(posedge CLK40);
        @(negedge CLK40);
        RESETn = 1'b1;
    end

endmodule

// ==== bench/busSizer_properties.sv ====
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the bus sizer ports
// Bound into every busSizer instance
// Covers local start width, data direction and split addressing
//////////////////////////////////////////////////////////////////////

`include "bus_consts.svh"

module busSizer_properties (
    input logic       CLK40,
    input logic       RESETn,
    input logic       tsAmigaN,
    input logic       tackN,
    input logic       teaN,
    input logic       taCpuN,
    input logic       dataCpuOe,
    input logic       dataAmigaOe,
    input logic [1:0] addrAmiga
);

    timeunit 1ns;
    timeprecision 1ps;

    // A local start is a single cycle strobe
    assert property (@(posedge CLK40) disable iff (!RESETn) !tsAmigaN |=> tsAmigaN)
        else $error("tsAmigaN low on two consecutive cycles");

    // Only one side drives data at a time
    assert property (@(posedge CLK40) disable iff (!RESETn) !(dataCpuOe && dataAmigaOe))
        else $error("both data output enables high");

    // A normal termination hidden from the CPU ends the first half of a split
    // Second local start follows after one turnaround cycle at address 2
    assert property (@(posedge CLK40) disable iff (!RESETn)
        $past(!tackN && teaN && taCpuN, 2)
        |-> (!tsAmigaN && addrAmiga == 2'(`SECOND_HALF_ADDR)))
        else $error("second half of split not started at address 2");

    // Local start stays inactive while reset is held
    assert property (@(posedge CLK40) (!RESETn && $past(!RESETn)) |-> tsAmigaN)
        else $error("tsAmigaN active during reset");

endmodule

bind busSizer busSizer_properties props0 (
    .CLK40(CLK40), .RESETn(RESETn), .tsAmigaN(tsAmigaN), .tackN(tackN), .teaN(teaN),
    .taCpuN(taCpuN), .dataCpuOe(dataCpuOe), .dataAmigaOe(dataAmigaOe),
    .addrAmiga(addrAmiga)
);

// ==== bench/busSizerTb.sv ====
//////////////////////////////////////////////////////////////////////
// Directed testbench for the bus sizer
// Acts as CPU and as a 32 or 16 bit peripheral with random wait states
//////////////////////////////////////////////////////////////////////

module busSizerTb;

    timeunit 1ns;
    timeprecision 1ps;

    import cycleTypesPkg::*;

    logic CLK40, RESETn, tsCpuN, rnw, portSize, tackN, teaN, tbiN, tciN;
    logic tsAmigaN, taCpuN, teaCpuN, tbiCpuN, tciCpuN, dataCpuOe, dataAmigaOe;
    sizeCode siz;
    logic [1:0] addrCpu, addrAmiga;
    logic [31:0] dataCpuIn, dataAmigaIn, dataCpuOut, dataAmigaOut;

    logic [15:0] lfsr = 16'd12629;
    logic [31:0] longMem [4];
    logic [15:0] wordMem [2];
    logic [1:0] startAddr [8];
    logic [15:0] highLanes [8];
    logic [31:0] ackData [4];
    logic injectError, errorSeen, tbiAtAck, tciAtAck;
    int startCount, accessIdx, ackCount, startsAtAck;
    int errs, testErrs, tests, failedTests;

    clockGen clk0 (.CLK40(CLK40), .RESETn(RESETn));
    busSizer dut0 (.*);

    // Fibonacci LFSR x^16+x^14+x^13+x^11+1
    // Stepped once for every bit taken
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = {lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5], lfsr[15:1]};
        end
        return v;
    endfunction

    task automatic check(input logic ok, input string msg);
        assert (ok) else begin
            $display("mismatch at %0t ns: %s", $time, msg);
            testErrs++;
        end
    endtask

    // Outputs are settled 10 ns before the rising edge
    task automatic waitSamplePoint();
        @(negedge CLK40);
        #10;
    endtask

    // Peripheral model answering each local start after 0 to 3 extra cycles
    initial begin : responder
        int waitCycles;
        forever begin
            @(negedge CLK40);
            if (RESETn && !tsAmigaN) begin
                startAddr[startCount % 8] = addrAmiga;
                startCount++;
                waitCycles = int'(randomBits(2));
                repeat (waitCycles + 1) @(negedge CLK40);
                highLanes[(startCount - 1) % 8] = dataAmigaOut[31:16];
                if (portSize) begin
                    // Word port lives on the high lanes only
                    if (!rnw) wordMem[addrAmiga[1]] = dataAmigaOut[31:16];
                    dataAmigaIn = {wordMem[addrAmiga[1]], 16'hdead};
                end else begin
                    if (!rnw) longMem[accessIdx % 4] = dataAmigaOut;
                    dataAmigaIn = longMem[accessIdx % 4];
                end
                accessIdx++;
                tackN = injectError;
                teaN = !injectError;
                @(negedge CLK40);
                tackN = 1'b1;
                teaN = 1'b1;
            end
        end
    end

    // One CPU transfer that waits for the expected acknowledges or an error
    task automatic cpuCycle(input logic rd, input sizeCode sz, input logic [1:0] ad,
                            input logic port, input logic [31:0] wd, input int acks);
        int t;
        @(negedge CLK40);
        rnw = rd;
        siz = sz;
        addrCpu = ad;
        portSize = port;
        dataCpuIn = wd;
        startCount = 0;
        accessIdx = 0;
        ackCount = 0;
        errorSeen = 1'b0;
        tsCpuN = 1'b0;
        @(negedge CLK40);
        tsCpuN = 1'b1;
        t = 0;
        while (ackCount < acks && !errorSeen && t < 40) begin
            waitSamplePoint();
            if (!taCpuN) begin
                ackData[ackCount % 4] = dataCpuOut;
                tbiAtAck = tbiCpuN;
                tciAtAck = tciCpuN;
                startsAtAck = startCount;
                check(dataCpuOe == rd && dataAmigaOe == !rd,
                      "data output enables at acknowledge");
                ackCount++;
            end
            if (!teaCpuN) errorSeen = 1'b1;
            t++;
        end
        if (ackCount < acks && !errorSeen) begin
            $display("timeout at %0t ns: CPU cycle never terminated", $time);
            testErrs++;
        end
        // Quiet window catches late acknowledges, extra local starts and enables left on
        repeat (6) begin
            waitSamplePoint();
            if (!taCpuN) ackCount++;
            check(!dataCpuOe && !dataAmigaOe, "data output enable left on after the cycle");
        end
    endtask

    task automatic report(input string name);
        tests++;
        if (testErrs != 0) failedTests++;
        errs += testErrs;
        $display("%s: %s", name, (testErrs == 0) ? "ok" : "FAILED");
        testErrs = 0;
    endtask

    task automatic longPortTransfers();
        longMem[0] = 32'h12345678;
        cpuCycle(1'b1, SIZE_LONG, 2'd0, 1'b0, 32'h0, 1);
        check(startCount == 1 && startAddr[0] == 2'd0, "long read local start");
        check(ackCount == 1 && ackData[0] == 32'h12345678, "long read data");
        cpuCycle(1'b0, SIZE_LONG, 2'd0, 1'b0, 32'hcafef00d, 1);
        check(startCount == 1 && startAddr[0] == 2'd0 && ackCount == 1,
              "long write start or ack count");
        check(longMem[0] == 32'hcafef00d, "long write data");
        report("long port pass-through");
    endtask

    task automatic splitLongWrite();
        cpuCycle(1'b0, SIZE_LONG, 2'd0, 1'b1, 32'ha1b2c3d4, 1);
        check(startCount == 2 && startAddr[0] == 2'd0 && startAddr[1] == 2'd2,
              "split write addresses");
        check(highLanes[0] == 16'ha1b2 && highLanes[1] == 16'hc3d4, "split write lanes");
        check(ackCount == 1 && startsAtAck == 2, "split write acknowledge");
        report("split long write");
    endtask

    task automatic splitLongRead();
        wordMem[0] = 16'h5a01;
        wordMem[1] = 16'h7e02;
        cpuCycle(1'b1, SIZE_LONG, 2'd0, 1'b1, 32'h0, 1);
        check(ackCount == 1 && ackData[0] == 32'h5a017e02, "split read data");
        report("split long read");
    endtask

    task automatic wordAtAddressTwo();
        wordMem[1] = 16'h4c4c;
        cpuCycle(1'b1, SIZE_WORD, 2'd2, 1'b1, 32'h0, 1);
        check(startCount == 1 && startAddr[0] == 2'd2, "word read local start");
        check(ackData[0][15:0] == 16'h4c4c, "word read low lanes");
        cpuCycle(1'b0, SIZE_WORD, 2'd2, 1'b1, 32'h00009b3e, 1);
        check(startCount == 1 && highLanes[0] == 16'h9b3e, "word write high lanes");
        check(wordMem[1] == 16'h9b3e, "word write data");
        report("word at address 2");
    endtask

    task automatic lineReadBursts();
        for (int i = 0; i < 4; i++) longMem[i] = randomBits(32);
        cpuCycle(1'b1, SIZE_LINE, 2'd0, 1'b0, 32'h0, 4);
        check(ackCount == 4 && startCount == 4, "line beat count");
        for (int i = 0; i < 4; i++) check(ackData[i] == longMem[i], "line beat data");
        @(negedge CLK40);
        tbiN = 1'b0;
        cpuCycle(1'b1, SIZE_LINE, 2'd0, 1'b0, 32'h0, 1);
        check(ackCount == 1 && startCount == 1, "burst inhibit beat count");
        @(negedge CLK40);
        tbiN = 1'b1;
        report("line read");
    endtask

    task automatic errorThenNormal();
        injectError = 1'b1;
        cpuCycle(1'b1, SIZE_LONG, 2'd0, 1'b0, 32'h0, 1);
        check(errorSeen && ackCount == 0, "error termination");
        @(negedge CLK40);
        injectError = 1'b0;
        tbiN = 1'b0;
        tciN = 1'b0;
        longMem[0] = 32'h0f1e2d3c;
        cpuCycle(1'b1, SIZE_LONG, 2'd0, 1'b0, 32'h0, 1);
        check(ackCount == 1 && ackData[0] == 32'h0f1e2d3c, "cycle after error");
        check(!tbiAtAck && !tciAtAck, "burst and cache inhibit pass-through");
        @(negedge CLK40);
        tbiN = 1'b1;
        tciN = 1'b1;
        report("error then normal");
    endtask

    initial begin : main
        int t;
        tsCpuN = 1'b1;
        rnw = 1'b1;
        siz = SIZE_LONG;
        addrCpu = 2'd0;
        portSize = 1'b0;
        tackN = 1'b1;
        teaN = 1'b1;
        tbiN = 1'b1;
        tciN = 1'b1;
        dataCpuIn = '0;
        dataAmigaIn = '0;
        injectError = 1'b0;
        {errs, testErrs, tests, failedTests, startCount, accessIdx} = '0;
        t = 0;
        while (RESETn !== 1'b1 && t < 100) begin
            @(posedge CLK40);
            t++;
        end
        if (RESETn !== 1'b1) begin
            $display("reset was never released");
            errs++;
        end
        longPortTransfers();
        splitLongWrite();
        splitLongRead();
        wordAtAddressTwo();
        lineReadBursts();
        errorThenNormal();
        $display("tests %0d, failed %0d, errors %0d", tests, failedTests, errs);
        if (errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Run limit in case a cycle hangs outside its own timeout
    initial begin : watchdog
        repeat (5000) @(posedge CLK40);
        $display("simulation ran past its cycle limit");
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/busTypesPkg.sv
hdl/cycleTypesPkg.sv
hdl/cycleDecoder.sv
hdl/cycleSequencer.sv
hdl/laneRouter.sv
hdl/busSizer.sv
bench/clockGen.sv
bench/busSizer_properties.sv
bench/busSizerTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bus sizer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module busSizerTb -f project.f -o VbusSizerTb

./obj_dir/VbusSizerTb | tee sim.log

# Pass only when the testbench printed its pass line
grep -q "^Verification passed$" sim.log
